/* Bender.yml */
package:
  name: soc_periph_hub

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/soc_hub_pkg.sv
      - verilog/addr_decode.sv
      - verilog/boot_rom.sv
      - verilog/clint_timer.sv
      - verilog/resp_combine.sv
      - verilog/soc_periph_hub.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/soc_periph_hub_tb.sv

/* dv/soc_periph_hub_tb.sv */
`timescale 1ns/100ps

`include "soc_hub_defs.svh"

module soc_periph_hub_tb;

  localparam int MAX_ENTRIES = 40;

  // One table row with optional level checks
  typedef struct packed {
    logic        we;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic        exp_err;
    logic [63:0] exp_rdata;
    logic        chain;
    logic [7:0]  rtc_edges;
    logic        chk_ipi;
    logic        chk_irq;
    logic        exp_lvl;
  } stim_t;

  logic                  clk_i;
  logic                  ndmreset_n;
  logic                  rtc_i;
  soc_hub_pkg::hub_req_t req_i;
  soc_hub_pkg::hub_rsp_t rsp_o;
  logic                  timer_irq_o;
  logic                  ipi_o;

  stim_t       stim [MAX_ENTRIES];
  string       names [MAX_ENTRIES];
  int          num_entries = 0;
  int          rtc_total = 0;
  int          error_count = 0;
  logic        table_ready = 1'b0;
  int unsigned lcg_state = 7;

  soc_periph_hub DUT (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .rsp_o       ( rsp_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // Reference model and table helpers
  // ----------------------------------------------------------
  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Upper half seed plus index, lower half its inverse
  function automatic logic [63:0] rom_word(input int unsigned idx);
    logic [31:0] hi;
    hi = `ROM_SEED + idx;
    return {hi, ~hi};
  endfunction

  task automatic add_entry(input string name, input logic we, input logic [31:0] addr,
                           input logic [63:0] wdata, input logic exp_err,
                           input logic [63:0] exp_rdata);
    stim_t e;
    e           = '0;
    e.we        = we;
    e.addr      = addr;
    e.wdata     = wdata;
    e.exp_err   = exp_err;
    e.exp_rdata = exp_rdata;
    names[num_entries] = name;
    stim[num_entries]  = e;
    num_entries++;
  endtask

  task automatic mark_chain();
    stim[num_entries-1].chain = 1'b1;
  endtask

  task automatic expect_ipi(input logic lvl);
    stim[num_entries-1].chk_ipi = 1'b1;
    stim[num_entries-1].exp_lvl = lvl;
  endtask

  task automatic expect_irq(input logic lvl);
    stim[num_entries-1].chk_irq = 1'b1;
    stim[num_entries-1].exp_lvl = lvl;
  endtask

  // rtc edges are given before the row's request
  task automatic add_rtc_edges(input int edges);
    stim[num_entries-1].rtc_edges = 8'(edges);
    rtc_total += edges;
  endtask

  task automatic build_table();
    int unsigned idx;
    add_entry("rom_first", 1'b0, `ROM_BASE, '0, 1'b0, rom_word(0));
    add_entry("rom_last", 1'b0, `ROM_BASE + 8 * 15, '0, 1'b0, rom_word(15));
    repeat (4) begin
      idx = (next_random() >> 16) % `ROM_WORDS;
      add_entry($sformatf("rom_rand_%0d", idx), 1'b0, `ROM_BASE + 8 * idx, '0, 1'b0,
                rom_word(idx));
    end
    // Decode errors
    add_entry("err_unmapped", 1'b0, 32'h3000_0000, '0, 1'b1, '0);
    add_entry("err_misaligned", 1'b0, `ROM_BASE + 4, '0, 1'b1, '0);
    add_entry("err_rom_write", 1'b1, `ROM_BASE + 8, 64'hDEAD_BEEF, 1'b1, '0);
    // Software interrupt
    add_entry("msip_set", 1'b1, `CLINT_BASE + `CLINT_MSIP_OFS, 64'd1, 1'b0, '0);
    expect_ipi(1'b1);
    add_entry("msip_read", 1'b0, `CLINT_BASE + `CLINT_MSIP_OFS, '0, 1'b0, 64'd1);
    expect_ipi(1'b1);
    add_entry("msip_clear", 1'b1, `CLINT_BASE + `CLINT_MSIP_OFS, 64'd0, 1'b0, '0);
    expect_ipi(1'b0);
    add_entry("msip_read_zero", 1'b0, `CLINT_BASE + `CLINT_MSIP_OFS, '0, 1'b0, '0);
    // mtime counts once per two rtc edges
    add_entry("mtime_clear", 1'b1, `CLINT_BASE + `CLINT_MTIME_OFS, 64'd0, 1'b0, '0);
    add_entry("mtime_count", 1'b0, `CLINT_BASE + `CLINT_MTIME_OFS, '0, 1'b0, 64'd3);
    add_rtc_edges(6);
    // Timer interrupt
    add_entry("cmp_above", 1'b1, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 64'd100, 1'b0, '0);
    expect_irq(1'b0);
    add_entry("cmp_read", 1'b0, `CLINT_BASE + `CLINT_MTIMECMP_OFS, '0, 1'b0, 64'd100);
    add_entry("cmp_zero", 1'b1, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 64'd0, 1'b0, '0);
    expect_irq(1'b1);
    add_entry("cmp_disarm", 1'b1, `CLINT_BASE + `CLINT_MTIMECMP_OFS, '1, 1'b0, '0);
    expect_irq(1'b0);
    // Back to back
    add_entry("b2b_rom", 1'b0, `ROM_BASE + 8 * 5, '0, 1'b0, rom_word(5));
    mark_chain();
    add_entry("b2b_clint", 1'b0, `CLINT_BASE + `CLINT_MTIME_OFS, '0, 1'b0, 64'd3);
    mark_chain();
    add_entry("b2b_none", 1'b0, 32'h0000_0000, '0, 1'b1, '0);
  endtask

  // ----------------------------------------------------------
  // Drivers and checkers
  // ----------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    error_count++;
    $display("Fail %s expected %h actual %h", name, exp, act);
    $display("ERRORS FOUND");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  // 8 cycles between rising edges
  task automatic pulse_rtc(input int edges);
    repeat (edges) begin
      @(posedge clk_i);
      #0.5;
      rtc_i = 1'b1;
      repeat (4) @(posedge clk_i);
      #0.5;
      rtc_i = 1'b0;
      repeat (3) @(posedge clk_i);
    end
  endtask

  task automatic drive_request(input int i);
    req_i.valid = 1'b1;
    req_i.we    = stim[i].we;
    req_i.addr  = stim[i].addr;
    req_i.wdata = stim[i].wdata;
  endtask

  task automatic check_response(input int i);
    assert (rsp_o.valid === 1'b1)
      else report_mismatch({names[i], " valid"}, 64'd1, 64'(rsp_o.valid));
    assert (rsp_o.err === stim[i].exp_err)
      else report_mismatch({names[i], " err"}, 64'(stim[i].exp_err), 64'(rsp_o.err));
    assert (rsp_o.rdata === stim[i].exp_rdata)
      else report_mismatch({names[i], " rdata"}, stim[i].exp_rdata, rsp_o.rdata);
  endtask

  task automatic check_levels(input int i);
    if (stim[i].chk_ipi) begin
      assert (ipi_o === stim[i].exp_lvl)
        else report_mismatch({names[i], " ipi"}, 64'(stim[i].exp_lvl), 64'(ipi_o));
    end
    if (stim[i].chk_irq) begin
      // Registered compare sees the new mtimecmp one cycle after the write
      @(posedge clk_i);
      #0.5;
      assert (timer_irq_o === stim[i].exp_lvl)
        else report_mismatch({names[i], " irq"}, 64'(stim[i].exp_lvl), 64'(timer_irq_o));
    end
  endtask

  task automatic run_table();
    int i;
    i = 0;
    while (i < num_entries) begin
      if (stim[i].rtc_edges != 0) begin
        pulse_rtc(stim[i].rtc_edges);
        repeat (8) @(posedge clk_i);
      end
      @(posedge clk_i);
      #0.5;
      drive_request(i);
      // Chained rows overlap a response with the next request
      while (stim[i].chain && i + 1 < num_entries) begin
        @(posedge clk_i);
        #0.5;
        check_response(i);
        i++;
        drive_request(i);
      end
      @(posedge clk_i);
      #0.5;
      req_i = '0;
      check_response(i);
      check_levels(i);
      i++;
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------------------------
  initial begin
    clk_i      = 1'b0;
    ndmreset_n = 1'b0;
    rtc_i      = 1'b0;
    req_i      = '0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk_i);
    #0.5;
    ndmreset_n = 1'b1;
    run_table();
    repeat (2) @(posedge clk_i);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    wait (table_ready);
    repeat ((num_entries + rtc_total) * 20) @(posedge clk_i);
    $display("Timeout: the test sequence did not finish in time");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

/* soc_periph_hub.f */
+incdir+verilog
verilog/soc_hub_pkg.sv
verilog/addr_decode.sv
verilog/boot_rom.sv
verilog/clint_timer.sv
verilog/resp_combine.sv
verilog/soc_periph_hub.sv
dv/soc_periph_hub_tb.sv

/* verilog/addr_decode.sv */
`timescale 1ns/100ps

`include "soc_hub_defs.svh"

module addr_decode (
  input  soc_hub_pkg::hub_req_t req_i,
  output soc_hub_pkg::target_e  tgt_o
);

  // ----------------------------------------------------------
  // Rule table
  // ----------------------------------------------------------
  localparam int unsigned NUM_RULES = 2;

  // End addresses are exclusive
  localparam logic [`HUB_ADDR_W-1:0] RULE_START [NUM_RULES] = '{
    `ROM_BASE,
    `CLINT_BASE
  };

  localparam logic [`HUB_ADDR_W-1:0] RULE_END [NUM_RULES] = '{
    `ROM_BASE + `ROM_LEN,
    `CLINT_BASE + `CLINT_LEN
  };

  localparam soc_hub_pkg::target_e RULE_TGT [NUM_RULES] = '{
    soc_hub_pkg::TGT_ROM,
    soc_hub_pkg::TGT_CLINT
  };

  soc_hub_pkg::target_e match_tgt;
  logic                 misaligned;
  logic                 rom_write;

  // Walk the rules; windows do not overlap
  always_comb begin
    match_tgt = soc_hub_pkg::TGT_NONE;
    for (int unsigned i = 0; i < NUM_RULES; i++) begin
      if (req_i.addr >= RULE_START[i] && req_i.addr < RULE_END[i]) begin
        match_tgt = RULE_TGT[i];
      end
    end
  end

  // Only whole 64-bit words are accessible
  assign misaligned = (req_i.addr[2:0] != 3'b000);
  assign rom_write  = req_i.we && (match_tgt == soc_hub_pkg::TGT_ROM);

  always_comb begin
    if (!req_i.valid || misaligned || rom_write) begin
      tgt_o = soc_hub_pkg::TGT_NONE;
    end else begin
      tgt_o = match_tgt;
    end
  end

  // The ROM must never see a write
  a_no_rom_write: assert final (req_i.we !== 1'b1 || tgt_o != soc_hub_pkg::TGT_ROM)
    else $error("ROM selected for a write request");

endmodule

/* verilog/boot_rom.sv */
`timescale 1ns/100ps

`include "soc_hub_defs.svh"

module boot_rom (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_hub_pkg::hub_req_t req_i,
  input  soc_hub_pkg::target_e  tgt_i,
  output soc_hub_pkg::rd_data_t rd_o
);

  soc_hub_pkg::hub_addr_u addr_u;
  logic [`HUB_DATA_W-1:0] rom_mem [`ROM_WORDS];
  logic                   rom_sel;
  logic                   rd_valid_q;
  logic [`HUB_DATA_W-1:0] rd_data_q;

  // ----------------------------------------------------------
  // ROM content
  // ----------------------------------------------------------
  for (genvar i = 0; i < `ROM_WORDS; i++) begin : g_rom_word
    localparam logic [31:0] HI_WORD = `ROM_SEED + i;
    assign rom_mem[i] = {HI_WORD, ~HI_WORD};
  end

  assign addr_u  = req_i.addr;
  assign rom_sel = (tgt_i == soc_hub_pkg::TGT_ROM);

  // ----------------------------------------------------------
  // Registered read port
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rom_sel;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rom_sel) begin
      rd_data_q <= rom_mem[addr_u.rom.word_idx];
    end
  end

  assign rd_o.valid = rd_valid_q;
  assign rd_o.data  = rd_data_q;

endmodule

/* verilog/clint_timer.sv */
`timescale 1ns/100ps

`include "soc_hub_defs.svh"

module clint_timer (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  soc_hub_pkg::hub_req_t req_i,
  input  soc_hub_pkg::target_e  tgt_i,
  output soc_hub_pkg::rd_data_t rd_o,
  output logic                  timer_irq_o,
  output logic                  ipi_o
);

  soc_hub_pkg::hub_addr_u addr_u;
  logic [15:0]            reg_ofs;
  logic                   clint_sel;
  logic                   wr_msip;
  logic                   wr_mtimecmp;
  logic                   wr_mtime;
  logic                   rd_req;
  logic [`HUB_DATA_W-1:0] rd_mux;

  logic                   msip_q;
  logic [`HUB_DATA_W-1:0] mtimecmp_q;
  logic [`HUB_DATA_W-1:0] mtime_q;
  logic                   timer_irq_q;

  logic [1:0]             rtc_sync_q;
  logic                   rtc_prev_q;
  logic                   rtc_div_q;
  logic                   rtc_rise;
  logic                   mtime_tick;

  logic                   rd_valid_q;
  logic [`HUB_DATA_W-1:0] rd_data_q;

  // ----------------------------------------------------------
  // Register decode
  // ----------------------------------------------------------
  assign addr_u    = req_i.addr;
  assign reg_ofs   = addr_u.clint.reg_ofs;
  assign clint_sel = (tgt_i == soc_hub_pkg::TGT_CLINT);

  assign wr_msip     = clint_sel && req_i.we && (reg_ofs == `CLINT_MSIP_OFS);
  assign wr_mtimecmp = clint_sel && req_i.we && (reg_ofs == `CLINT_MTIMECMP_OFS);
  assign wr_mtime    = clint_sel && req_i.we && (reg_ofs == `CLINT_MTIME_OFS);
  assign rd_req      = clint_sel && !req_i.we;

  // Unknown offsets read as zero
  always_comb begin
    case (reg_ofs)
      `CLINT_MSIP_OFS:     rd_mux = {{(`HUB_DATA_W-1){1'b0}}, msip_q};
      `CLINT_MTIMECMP_OFS: rd_mux = mtimecmp_q;
      `CLINT_MTIME_OFS:    rd_mux = mtime_q;
      default:             rd_mux = '0;
    endcase
  end

  // ----------------------------------------------------------
  // RTC synchronizer and divide by two
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      rtc_div_q  <= rtc_div_q ^ rtc_rise;
    end
  end

  assign rtc_rise = rtc_sync_q[1] && !rtc_prev_q;
  // Count when the divider is about to go high
  assign mtime_tick = rtc_rise && !rtc_div_q;

  // ----------------------------------------------------------
  // Timer registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q      <= 1'b0;
      mtimecmp_q  <= '1;
      mtime_q     <= '0;
      timer_irq_q <= 1'b0;
    end else begin
      if (wr_msip) begin
        msip_q <= req_i.wdata[0];
      end
      if (wr_mtimecmp) begin
        mtimecmp_q <= req_i.wdata;
      end
      // Host write wins over a tick
      if (wr_mtime) begin
        mtime_q <= req_i.wdata;
      end else if (mtime_tick) begin
        mtime_q <= mtime_q + 64'd1;
      end
      timer_irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // ----------------------------------------------------------
  // Read port
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= rd_req;
    end
  end

  // Captures the value from before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rd_data_q <= rd_mux;
    end
  end

  assign rd_o.valid  = rd_valid_q;
  assign rd_o.data   = rd_data_q;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = msip_q;

  // Disarmed compare keeps the interrupt low from the next cycle on
  a_irq_disarmed: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (mtimecmp_q == '1 && mtime_q != '1) |=> !timer_irq_o)
    else $error("timer_irq_o high with mtimecmp all ones");

endmodule

/* verilog/resp_combine.sv */
`timescale 1ns/100ps

module resp_combine (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  soc_hub_pkg::hub_req_t req_i,
  input  soc_hub_pkg::target_e  tgt_i,
  input  soc_hub_pkg::rd_data_t rom_rd_i,
  input  soc_hub_pkg::rd_data_t clint_rd_i,
  output soc_hub_pkg::hub_rsp_t rsp_o
);

  logic        valid_q;
  logic        err_q;
  logic [63:0] rom_data;
  logic [63:0] clint_data;

  // ----------------------------------------------------------
  // Request tracking
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
      err_q   <= req_i.valid && (tgt_i == soc_hub_pkg::TGT_NONE);
    end
  end

  // ----------------------------------------------------------
  // Read data merge
  // ----------------------------------------------------------
  // Idle targets contribute nothing
  assign rom_data   = rom_rd_i.valid ? rom_rd_i.data : '0;
  assign clint_data = clint_rd_i.valid ? clint_rd_i.data : '0;

  // Writes and errors come back with zero data
  always_comb begin
    rsp_o.valid = valid_q;
    rsp_o.err   = err_q;
    rsp_o.rdata = rom_data | clint_data;
  end

  // One response for each request, one cycle later
  a_rsp_follows_req: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    rsp_o.valid == $past(req_i.valid))
    else $error("response valid does not follow request valid");

  // ROM and CLINT never answer in the same cycle
  a_single_source: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0({rom_rd_i.valid, clint_rd_i.valid}))
    else $error("ROM and CLINT read data valid together");

endmodule

/* verilog/soc_hub_defs.svh */
`ifndef SOC_HUB_DEFS_SVH
`define SOC_HUB_DEFS_SVH

// ----------------------------------------------------------
// Bus widths
// ----------------------------------------------------------
`define HUB_ADDR_W 32
`define HUB_DATA_W 64

// ----------------------------------------------------------
// Address map
// ----------------------------------------------------------
// Boot ROM holds one 64-bit word per 8 bytes
`define ROM_BASE  32'h0001_0000
`define ROM_WORDS 16
`define ROM_LEN   (`ROM_WORDS * 8)

// Core-local timer window
`define CLINT_BASE 32'h0200_0000
`define CLINT_LEN  32'h0001_0000

// Register offsets inside the CLINT window
`define CLINT_MSIP_OFS     16'h0000
`define CLINT_MTIMECMP_OFS 16'h4000
`define CLINT_MTIME_OFS    16'hBFF8

// Upper half of ROM word i is this seed plus i
// lower half is its inverse
`define ROM_SEED 32'hB007_0000

`endif

/* verilog/soc_hub_pkg.sv */
`include "soc_hub_defs.svh"

package soc_hub_pkg;

  // ----------------------------------------------------------
  // Host request and response
  // ----------------------------------------------------------
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`HUB_ADDR_W-1:0] addr;
    logic [`HUB_DATA_W-1:0] wdata;
  } hub_req_t;

  // One response per request, one cycle later
  typedef struct packed {
    logic                   valid;
    logic                   err;
    logic [`HUB_DATA_W-1:0] rdata;
  } hub_rsp_t;

  // Decoder result
  typedef enum logic [1:0] {
    TGT_NONE  = 2'd0,
    TGT_ROM   = 2'd1,
    TGT_CLINT = 2'd2
  } target_e;

  // ----------------------------------------------------------
  // Two views of one request address
  // ----------------------------------------------------------
  // ROM window as word index plus byte offset
  typedef struct packed {
    logic [24:0] region;
    logic [3:0]  word_idx;
    logic [2:0]  byte_ofs;
  } rom_addr_t;

  // CLINT window as 64 KiB page plus register offset
  typedef struct packed {
    logic [15:0] region;
    logic [15:0] reg_ofs;
  } clint_addr_t;

  typedef union packed {
    rom_addr_t   rom;
    clint_addr_t clint;
  } hub_addr_u;

  // Read result of one target
  typedef struct packed {
    logic                   valid;
    logic [`HUB_DATA_W-1:0] data;
  } rd_data_t;

endpackage

/* verilog/soc_periph_hub.sv */
`timescale 1ns/100ps

module soc_periph_hub (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  soc_hub_pkg::hub_req_t req_i,
  output soc_hub_pkg::hub_rsp_t rsp_o,
  output logic                  timer_irq_o,
  output logic                  ipi_o
);

  soc_hub_pkg::target_e  tgt;
  soc_hub_pkg::rd_data_t rom_rd;
  soc_hub_pkg::rd_data_t clint_rd;

  // ----------------------------------------------------------
  // Decode
  // ----------------------------------------------------------
  addr_decode i_addr_decode (
    .req_i ( req_i ),
    .tgt_o ( tgt   )
  );

  // ----------------------------------------------------------
  // Targets
  // ----------------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( req_i      ),
    .tgt_i      ( tgt        ),
    .rd_o       ( rom_rd     )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .tgt_i       ( tgt         ),
    .rd_o        ( clint_rd    ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // Single response strobe back to the host
  resp_combine i_resp_combine (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .req_i      ( req_i      ),
    .tgt_i      ( tgt        ),
    .rom_rd_i   ( rom_rd     ),
    .clint_rd_i ( clint_rd   ),
    .rsp_o      ( rsp_o      )
  );

endmodule
